//--- fpm_consts.svh
// Binary32 multiplier constants
`ifndef FPM_CONSTS_SVH
`define FPM_CONSTS_SVH

// ==============================
// Format widths
// ==============================

// Biased exponent field
`define FPM_EXP_W 8
// Stored fraction, hidden bit excluded
`define FPM_FRAC_W 23
// Significand with hidden bit restored
`define FPM_SIG_W 24
// Full significand product
`define FPM_PROD_W 48

// ==============================
// Exponent limits
// ==============================

`define FPM_BIAS 127
// All-ones exponent, infinity and NaN
`define FPM_EXP_MAX 255
// Signed internal exponent, holds -127 up to 383
`define FPM_XEXP_W 10

// Canonical quiet NaN
`define FPM_QNAN 32'h7FC00000

// Default pipeline depth of the significand array
`define FPM_MUL_STAGES 2

`endif

//--- fp_format_pkg.sv
// Binary32 word format
`include "fpm_consts.svh"

package fp_format_pkg;

    // ==============================
    // Operand and result word
    // ==============================

    // One 32-bit word, seen two ways
    // Raw view for whole-word compares and constants
    // Field view for decoding sign, exponent and fraction
    typedef union packed {
        logic [`FPM_EXP_W+`FPM_FRAC_W:0] bits;
        struct packed {
            // Sign, 1 means negative
            logic                   sign;
            // Biased exponent
            logic [`FPM_EXP_W-1:0]  exponent;
            // Fraction without hidden bit
            logic [`FPM_FRAC_W-1:0] fraction;
        } fields;
    } fp_word_u;

endpackage

//--- sig_multiplier.sv
// Pipelined significand multiplier
`include "fpm_consts.svh"

module sig_multiplier #(
    parameter int mul_stages_p = `FPM_MUL_STAGES
) (
    input  logic                     clk_i,
    input  fp_format_pkg::fp_word_u  a_i,
    input  fp_format_pkg::fp_word_u  b_i,
    output logic [`FPM_PROD_W-1:0]   product_o
);

    // Rows handled per stage, last stages may get fewer or none
    localparam int rows_per_stage_lp = (`FPM_SIG_W + mul_stages_p - 1) / mul_stages_p;
    // Zero padding from significand up to product width
    localparam int pad_w_lp = `FPM_PROD_W - `FPM_SIG_W;

    // Multiplicand and multiplier as seen by each stage
    logic [`FPM_SIG_W-1:0]  mcand_q  [mul_stages_p];
    logic [`FPM_SIG_W-1:0]  mplier_q [mul_stages_p];
    // Partial sum leaving each stage
    logic [`FPM_PROD_W-1:0] acc_q    [1:mul_stages_p];

    // ==============================
    // Operand register
    // ==============================

    // Hidden bit is 1 for any nonzero exponent
    always_ff @(posedge clk_i) begin
        mcand_q[0]  <= {(a_i.fields.exponent != '0), a_i.fields.fraction};
        mplier_q[0] <= {(b_i.fields.exponent != '0), b_i.fields.fraction};
    end

    // ==============================
    // Row groups
    // ==============================

    for (genvar s = 0; s < mul_stages_p; s++) begin : g_stage
        localparam int first_row_lp = s * rows_per_stage_lp;

        logic [`FPM_PROD_W-1:0] acc_in;
        logic [`FPM_PROD_W-1:0] acc_sum;

        // First group starts from an empty sum
        if (s == 0) begin : g_first
            assign acc_in = '0;
        end else begin : g_next
            assign acc_in = acc_q[s];
        end

        // Add the shifted multiplicand for each set multiplier bit in this group
        always_comb begin : row_sum
            logic [`FPM_SIG_W-1:0] row_sel;
            acc_sum = acc_in;
            for (int r = 0; r < rows_per_stage_lp; r++) begin
                // Rows past the top bit shift to zero and add nothing
                row_sel = mplier_q[s] >> (first_row_lp + r);
                if (row_sel[0]) begin
                    acc_sum = acc_sum + ({{pad_w_lp{1'b0}}, mcand_q[s]} << (first_row_lp + r));
                end
            end
        end

        always_ff @(posedge clk_i) begin
            acc_q[s+1] <= acc_sum;
        end

        // Operands ride along with their partial sum
        if (s < mul_stages_p - 1) begin : g_fwd
            always_ff @(posedge clk_i) begin
                mcand_q[s+1]  <= mcand_q[s];
                mplier_q[s+1] <= mplier_q[s];
            end
        end
    end

    assign product_o = acc_q[mul_stages_p];

    // Two normal significands are each at least 1.0, so the product is at least 1.0
    assert property (@(posedge clk_i)
        $past((a_i.fields.exponent != '0) && (b_i.fields.exponent != '0), mul_stages_p + 1)
        |-> (product_o[`FPM_PROD_W-1 -: 2] != 2'b00))
        else $error("significand product lost its leading bits");

endmodule

//--- exp_sign_path.sv
// Exponent, sign and operand class path
`include "fpm_consts.svh"

module exp_sign_path #(
    parameter int mul_stages_p = `FPM_MUL_STAGES
) (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  fp_format_pkg::fp_word_u        a_i,
    input  fp_format_pkg::fp_word_u        b_i,
    input  logic                           valid_i,
    output logic                           valid_o,
    output logic                           sign_o,
    output logic signed [`FPM_XEXP_W-1:0]  exp_o,
    output logic                           special_inf_o,
    output logic                           special_zero_o,
    output logic                           invalid_o
);

    // Payload is sign, three class flags and the exponent
    localparam int pay_w_lp = `FPM_XEXP_W + 4;
    localparam int depth_lp = mul_stages_p + 1;

    // Per-operand class
    logic a_exp_max;
    logic b_exp_max;
    logic a_exp_zero;
    logic b_exp_zero;
    logic a_frac_zero;
    logic b_frac_zero;
    logic a_nan;
    logic b_nan;
    logic a_inf;
    logic b_inf;
    logic a_zero;
    logic b_zero;
    logic a_sub;
    logic b_sub;
    // Normal operand, neither end of the exponent range
    logic a_norm;
    logic b_norm;

    // Decided result class
    logic invalid;
    logic special_inf;
    logic special_zero;
    logic sign;
    logic signed [`FPM_XEXP_W-1:0] exp_sum;

    // Delay line
    logic [pay_w_lp-1:0] pay_q [depth_lp];
    logic [depth_lp-1:0] valid_q;

    // ==============================
    // Classification
    // ==============================

    assign a_exp_max   = (a_i.fields.exponent == `FPM_EXP_W'(`FPM_EXP_MAX));
    assign b_exp_max   = (b_i.fields.exponent == `FPM_EXP_W'(`FPM_EXP_MAX));
    assign a_exp_zero  = (a_i.fields.exponent == '0);
    assign b_exp_zero  = (b_i.fields.exponent == '0);
    assign a_frac_zero = (a_i.fields.fraction == '0);
    assign b_frac_zero = (b_i.fields.fraction == '0);

    assign a_nan  = a_exp_max & ~a_frac_zero;
    assign b_nan  = b_exp_max & ~b_frac_zero;
    assign a_inf  = a_exp_max & a_frac_zero;
    assign b_inf  = b_exp_max & b_frac_zero;
    assign a_zero = a_exp_zero & a_frac_zero;
    assign b_zero = b_exp_zero & b_frac_zero;
    // Subnormal inputs are not supported and count as invalid
    assign a_sub  = a_exp_zero & ~a_frac_zero;
    assign b_sub  = b_exp_zero & ~b_frac_zero;
    assign a_norm = ~a_exp_max & ~a_exp_zero;
    assign b_norm = ~b_exp_max & ~b_exp_zero;

    // NaN, infinity times zero or a subnormal input
    assign invalid      = a_nan | b_nan | (a_inf & b_zero) | (a_zero & b_inf) | a_sub | b_sub;
    // Infinity meets infinity or a normal number
    assign special_inf  = (a_inf & (b_inf | b_norm)) | (b_inf & a_norm);
    // Zero meets zero or a normal number
    assign special_zero = (a_zero & (b_zero | b_norm)) | (b_zero & a_norm);

    // ==============================
    // Sign and exponent
    // ==============================

    assign sign = a_i.fields.sign ^ b_i.fields.sign;

    // Zero-extend both fields, then remove one bias
    assign exp_sum = $signed({2'b00, a_i.fields.exponent})
                   + $signed({2'b00, b_i.fields.exponent})
                   - $signed(`FPM_XEXP_W'(`FPM_BIAS));

    // ==============================
    // Delay to meet the product
    // ==============================

    always_ff @(posedge clk_i) begin
        pay_q[0] <= {sign, invalid, special_inf, special_zero, exp_sum};
        for (int i = 1; i < depth_lp; i++) begin
            pay_q[i] <= pay_q[i-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[depth_lp-2:0], valid_i};
        end
    end

    assign valid_o = valid_q[depth_lp-1];
    assign {sign_o, invalid_o, special_inf_o, special_zero_o, exp_o} = pay_q[depth_lp-1];

    // Decoded classes exclude each other at the product stage
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o |-> $onehot0({invalid_o, special_inf_o, special_zero_o}))
        else $error("more than one special class at the product stage");

endmodule

//--- result_normalizer.sv
// Product normalizer and output register
`include "fpm_consts.svh"

module result_normalizer (
    input  logic                           clk_i,
    input  logic                           rst_n_i,
    input  logic                           valid_i,
    input  logic                           sign_i,
    input  logic signed [`FPM_XEXP_W-1:0]  exp_i,
    input  logic                           special_inf_i,
    input  logic                           special_zero_i,
    input  logic                           invalid_i,
    input  logic [`FPM_PROD_W-1:0]         product_i,
    output fp_format_pkg::fp_word_u        result_o,
    output logic                           valid_o,
    output logic                           invalid_o,
    output logic                           overflow_o,
    output logic                           underflow_o,
    output logic                           inexact_o,
    output logic                           guard_o,
    output logic                           round_o,
    output logic                           sticky_o
);

    localparam int prod_w_lp = `FPM_PROD_W;
    localparam int frac_w_lp = `FPM_FRAC_W;
    // Fraction sits right below the hidden bit at prod_w_lp - 2
    localparam int frac_lsb_lp = prod_w_lp - 2 - frac_w_lp;
    localparam logic signed [`FPM_XEXP_W-1:0] exp_max_lp = `FPM_XEXP_W'(`FPM_EXP_MAX);

    // Normalized product and exponent
    logic [prod_w_lp-1:0]            norm_prod;
    logic signed [`FPM_XEXP_W-1:0]   norm_exp;
    logic signed [`FPM_XEXP_W-1:0]   shift_full;
    logic [5:0]                      shift_amt;
    logic [2*prod_w_lp-1:0]          denorm_wide;
    logic [prod_w_lp-1:0]            denorm_prod;
    logic [prod_w_lp-1:0]            lost_bits;

    // Next-state values
    fp_format_pkg::fp_word_u result_d;
    logic overflow;
    logic underflow;
    logic guard;
    logic round;
    logic sticky;

    // ==============================
    // Normalization
    // ==============================

    // Product in [1, 4), one right shift at most
    assign norm_prod = product_i[prod_w_lp-1] ? (product_i >> 1) : product_i;
    assign norm_exp  = product_i[prod_w_lp-1] ? (exp_i + 10'sd1) : exp_i;

    // Range checks on the adjusted exponent
    assign overflow  = (norm_exp >= exp_max_lp);
    assign underflow = (norm_exp <= 10'sd0);

    // Gradual underflow shifts by 1 - e, capped at the product width
    assign shift_full = 10'sd1 - norm_exp;

    always_comb begin
        shift_amt = '0;
        if (underflow) begin
            if (shift_full > 10'(prod_w_lp)) begin
                shift_amt = 6'(prod_w_lp);
            end else begin
                shift_amt = shift_full[5:0];
            end
        end
    end

    // Upper half keeps the shifted product, lower half catches what falls out
    assign denorm_wide = {norm_prod, {prod_w_lp{1'b0}}} >> shift_amt;
    assign denorm_prod = denorm_wide[2*prod_w_lp-1:prod_w_lp];
    assign lost_bits   = denorm_wide[prod_w_lp-1:0];

    // ==============================
    // Result selection
    // ==============================

    always_comb begin
        result_d = '0;
        guard    = 1'b0;
        round    = 1'b0;
        sticky   = 1'b0;
        if (invalid_i) begin
            result_d.bits = `FPM_QNAN;
        end else if (special_inf_i || overflow) begin
            // Signed infinity, round bits stay clear
            result_d.fields.sign     = sign_i;
            result_d.fields.exponent = '1;
        end else if (special_zero_i) begin
            result_d.fields.sign = sign_i;
        end else begin
            result_d.fields.sign     = sign_i;
            result_d.fields.exponent = underflow ? '0 : norm_exp[`FPM_EXP_W-1:0];
            result_d.fields.fraction = denorm_prod[frac_lsb_lp +: frac_w_lp];
            guard  = denorm_prod[frac_lsb_lp-1];
            round  = denorm_prod[frac_lsb_lp-2];
            sticky = (denorm_prod[frac_lsb_lp-3:0] != '0) | (lost_bits != '0);
        end
    end

    // ==============================
    // Output register
    // ==============================

    // Result word
    always_ff @(posedge clk_i) begin
        result_o <= result_d;
    end

    // Flags only count on a valid cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o     <= 1'b0;
            invalid_o   <= 1'b0;
            overflow_o  <= 1'b0;
            underflow_o <= 1'b0;
            inexact_o   <= 1'b0;
            guard_o     <= 1'b0;
            round_o     <= 1'b0;
            sticky_o    <= 1'b0;
        end else begin
            valid_o     <= valid_i;
            invalid_o   <= valid_i & invalid_i;
            overflow_o  <= valid_i & ~invalid_i & ~special_inf_i & ~special_zero_i & overflow;
            underflow_o <= valid_i & ~invalid_i & ~special_inf_i & ~special_zero_i & underflow;
            // Inexact whenever any dropped bit was set
            inexact_o   <= valid_i & (guard | round | sticky);
            guard_o     <= valid_i & guard;
            round_o     <= valid_i & round;
            sticky_o    <= valid_i & sticky;
        end
    end

    // A result cannot be too large and too small at once
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(overflow_o && underflow_o))
        else $error("overflow and underflow set together");

endmodule

//--- fp_multiplier.sv
// Binary32 multiplier top
`include "fpm_consts.svh"

module fp_multiplier (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  fp_format_pkg::fp_word_u  a_i,
    input  fp_format_pkg::fp_word_u  b_i,
    input  logic                     valid_i,
    output fp_format_pkg::fp_word_u  result_o,
    output logic                     valid_o,
    output logic                     invalid_o,
    output logic                     overflow_o,
    output logic                     underflow_o,
    output logic                     inexact_o,
    output logic                     guard_o,
    output logic                     round_o,
    output logic                     sticky_o
);

    // Latency is mul_stages_lp + 2
    localparam int mul_stages_lp = `FPM_MUL_STAGES;

    // Significand path
    logic [`FPM_PROD_W-1:0] product;

    // Exponent, sign and class path
    logic                          path_valid;
    logic                          path_sign;
    logic signed [`FPM_XEXP_W-1:0] path_exp;
    logic                          path_inf;
    logic                          path_zero;
    logic                          path_invalid;

    // ==============================
    // Parallel paths
    // ==============================

    sig_multiplier #(
        .mul_stages_p (mul_stages_lp)
    ) sig_mul_i (
        .clk_i     (clk_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .product_o (product)
    );

    exp_sign_path #(
        .mul_stages_p (mul_stages_lp)
    ) exp_path_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .a_i            (a_i),
        .b_i            (b_i),
        .valid_i        (valid_i),
        .valid_o        (path_valid),
        .sign_o         (path_sign),
        .exp_o          (path_exp),
        .special_inf_o  (path_inf),
        .special_zero_o (path_zero),
        .invalid_o      (path_invalid)
    );

    // ==============================
    // Merge and register
    // ==============================

    result_normalizer normalizer_i (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (path_valid),
        .sign_i         (path_sign),
        .exp_i          (path_exp),
        .special_inf_i  (path_inf),
        .special_zero_i (path_zero),
        .invalid_i      (path_invalid),
        .product_i      (product),
        .result_o       (result_o),
        .valid_o        (valid_o),
        .invalid_o      (invalid_o),
        .overflow_o     (overflow_o),
        .underflow_o    (underflow_o),
        .inexact_o      (inexact_o),
        .guard_o        (guard_o),
        .round_o        (round_o),
        .sticky_o       (sticky_o)
    );

endmodule

//--- tb_fp_ref.svh
// Binary32 multiply reference model
`ifndef TB_FP_REF_SVH
`define TB_FP_REF_SVH

// Flags packed as {invalid, overflow, underflow, inexact, guard, round, sticky}
function automatic void fp_mul_ref(
    input  fp_format_pkg::fp_word_u a,
    input  fp_format_pkg::fp_word_u b,
    output fp_format_pkg::fp_word_u res,
    output logic [6:0]              flags
);
    logic        a_nan, b_nan, a_inf, b_inf, a_zero, b_zero, a_sub, b_sub;
    logic        s;
    logic [47:0] p;
    logic [95:0] wide;
    logic [47:0] kept;
    logic [47:0] lost;
    int          e;
    int          sh;
    a_nan  = (a.fields.exponent == 8'hFF) && (a.fields.fraction != '0);
    b_nan  = (b.fields.exponent == 8'hFF) && (b.fields.fraction != '0);
    a_inf  = (a.fields.exponent == 8'hFF) && (a.fields.fraction == '0);
    b_inf  = (b.fields.exponent == 8'hFF) && (b.fields.fraction == '0);
    a_zero = (a.fields.exponent == 8'h00) && (a.fields.fraction == '0);
    b_zero = (b.fields.exponent == 8'h00) && (b.fields.fraction == '0);
    a_sub  = (a.fields.exponent == 8'h00) && (a.fields.fraction != '0);
    b_sub  = (b.fields.exponent == 8'h00) && (b.fields.fraction != '0);
    s      = a.fields.sign ^ b.fields.sign;
    res    = '0;
    flags  = '0;
    if (a_nan || b_nan || a_sub || b_sub || (a_inf && b_zero) || (a_zero && b_inf)) begin
        res.bits = `FPM_QNAN;
        flags[6] = 1'b1;
    end else if (a_inf || b_inf) begin
        res.fields.sign     = s;
        res.fields.exponent = 8'hFF;
    end else if (a_zero || b_zero) begin
        res.fields.sign = s;
    end else begin
        // Both normal, full 48-bit significand product
        p = {24'b0, 1'b1, a.fields.fraction} * {24'b0, 1'b1, b.fields.fraction};
        e = int'(a.fields.exponent) + int'(b.fields.exponent) - 127;
        if (p[47]) begin
            p = p >> 1;
            e = e + 1;
        end
        res.fields.sign = s;
        if (e >= 255) begin
            res.fields.exponent = 8'hFF;
            flags[5]            = 1'b1;
        end else begin
            sh = 0;
            if (e <= 0) begin
                flags[4] = 1'b1;
                sh       = (1 - e > 48) ? 48 : 1 - e;
            end
            // Lower half collects everything shifted out below bit 0
            wide = {p, 48'b0} >> sh;
            kept = wide[95:48];
            lost = wide[47:0];
            res.fields.exponent = (e <= 0) ? 8'h00 : 8'(e);
            res.fields.fraction = kept[45:23];
            flags[2] = kept[22];
            flags[1] = kept[21];
            flags[0] = (kept[20:0] != '0) || (lost != '0);
            flags[3] = flags[2] | flags[1] | flags[0];
        end
    end
endfunction

`endif

//--- tb_fp_multiplier.sv
// Floating-point multiplier testbench
`include "fpm_consts.svh"

module tb_fp_multiplier;

    // Operand pair to result, in clock edges
    localparam int latency_lp     = `FPM_MUL_STAGES + 2;
    localparam int drain_limit_lp = 4 * latency_lp + 10;

    logic                    clk_i;
    logic                    rst_n_i;
    fp_format_pkg::fp_word_u a_i;
    fp_format_pkg::fp_word_u b_i;
    logic                    valid_i;
    fp_format_pkg::fp_word_u result_o;
    logic                    valid_o;
    logic                    invalid_o;
    logic                    overflow_o;
    logic                    underflow_o;
    logic                    inexact_o;
    logic                    guard_o;
    logic                    round_o;
    logic                    sticky_o;
    logic [6:0]              dut_flags;
    int                      cycle;

    // Expected results in issue order
    fp_format_pkg::fp_word_u exp_word_q  [$];
    logic [6:0]              exp_flags_q [$];
    int                      issue_q     [$];

    `include "tb_fp_ref.svh"

    fp_multiplier dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .a_i         (a_i),
        .b_i         (b_i),
        .valid_i     (valid_i),
        .result_o    (result_o),
        .valid_o     (valid_o),
        .invalid_o   (invalid_o),
        .overflow_o  (overflow_o),
        .underflow_o (underflow_o),
        .inexact_o   (inexact_o),
        .guard_o     (guard_o),
        .round_o     (round_o),
        .sticky_o    (sticky_o)
    );

    // Same packing as the reference flags
    assign dut_flags = {invalid_o, overflow_o, underflow_o, inexact_o, guard_o, round_o, sticky_o};

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    // ==============================
    // Checks
    // ==============================

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input fp_format_pkg::fp_word_u got, input fp_format_pkg::fp_word_u exp);
        if (got.bits !== exp.bits) begin
            $display("mismatch at %0t: result %h, expected %h", $time, got.bits, exp.bits);
            stop_with_failure("result word differs from the reference");
        end
    endtask

    task automatic check_flags(input logic [6:0] got, input logic [6:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s flags %b, expected %b", $time, what, got, exp);
            stop_with_failure("flags or round bits differ from the reference");
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: latency %0d, expected %0d", $time, got, exp);
            stop_with_failure("result arrived at the wrong cycle");
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================

    // Drive one pair, queue its expected result, move to the next drive point
    task automatic issue_pair(input logic [31:0] a, input logic [31:0] b);
        fp_format_pkg::fp_word_u exp_word;
        logic [6:0]              exp_flags;
        a_i.bits = a;
        b_i.bits = b;
        valid_i  = 1'b1;
        fp_mul_ref(a_i, b_i, exp_word, exp_flags);
        exp_word_q.push_back(exp_word);
        exp_flags_q.push_back(exp_flags);
        // Issue cycle is the one the pair is presented in
        issue_q.push_back(cycle);
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    function automatic logic [31:0] random_normal(input int lo, input int hi);
        fp_format_pkg::fp_word_u w;
        w.fields.sign     = 1'($urandom);
        w.fields.exponent = 8'($urandom_range(hi, lo));
        w.fields.fraction = 23'($urandom);
        return w.bits;
    endfunction

    // Mostly back to back, with an occasional short gap
    task automatic random_run(input int count, input int lo, input int hi);
        for (int i = 0; i < count; i++) begin
            issue_pair(random_normal(lo, hi), random_normal(lo, hi));
            if ($urandom_range(3, 0) == 0) begin
                idle(int'($urandom_range(3, 1)));
            end
        end
    endtask

    // ==============================
    // Compare process
    // ==============================

    initial begin : compare_results
        forever begin
            @(posedge clk_i);
            #10;
            if (valid_o !== 1'b0 && valid_o !== 1'b1) begin
                stop_with_failure("valid_o is unknown");
            end else if (valid_o) begin
                if (issue_q.size() == 0) begin
                    stop_with_failure("valid_o rose with no operand pair in flight");
                end else begin
                    check_latency(cycle - issue_q.pop_front(), latency_lp);
                    check_word(result_o, exp_word_q.pop_front());
                    check_flags(dut_flags, exp_flags_q.pop_front(), "result");
                end
            end else begin
                // Nothing valid, so every flag must be clear
                check_flags(dut_flags, 7'b0, "idle");
                if (issue_q.size() != 0 && cycle - issue_q[0] > latency_lp) begin
                    stop_with_failure("no result arrived for an operand pair in flight");
                end
            end
        end
    end

    // ==============================
    // Main sequence
    // ==============================

    initial begin : run_test
        int waited;
        void'($urandom(32'hae6f_b730));
        cycle   = 0;
        rst_n_i = 1'b0;
        valid_i = 1'b0;
        a_i     = '0;
        b_i     = '0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        idle(2);
        // Exact products
        issue_pair(32'h3FC00000, 32'h40000000);
        issue_pair(32'hC0400000, 32'h40A00000);
        issue_pair(32'h3F800000, 32'h3F800000);
        idle(3);
        // Overflow, then gradual and total underflow
        issue_pair(32'h7F000000, 32'h40000000);
        issue_pair(32'hFF7FFFFF, 32'h7F7FFFFF);
        issue_pair(32'h00800000, 32'h3F000000);
        issue_pair(32'h80FFFFFF, 32'h33800001);
        issue_pair(32'h00800000, 32'h00800000);
        // NaN, inf x zero, subnormal, inf x normal, zero x normal
        issue_pair(32'h7FC00001, 32'h3F800000);
        issue_pair(32'h7F800000, 32'h00000000);
        issue_pair(32'h80000000, 32'hFF800000);
        issue_pair(32'h00000001, 32'h3F800000);
        issue_pair(32'h7F800000, 32'hC0000000);
        issue_pair(32'h00000000, 32'hC0400000);
        issue_pair(32'h80000000, 32'h80000000);
        issue_pair(32'hFF800000, 32'h7F800000);
        issue_pair(32'hFFFFFFFF, 32'h00000000);
        random_run(2000, 64, 190);
        random_run(200, 180, 254);
        random_run(200, 1, 40);
        // Drain what is still in flight
        waited = 0;
        while (issue_q.size() != 0 && waited < drain_limit_lp) begin
            @(posedge clk_i);
            #20;
            waited++;
        end
        // A few quiet cycles to catch a stray valid_o
        repeat (latency_lp) begin
            @(posedge clk_i);
            #20;
        end
        if (issue_q.size() == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            stop_with_failure("results still missing after the last operand pair");
        end
    end

endmodule

//--- verilog.f
+incdir+.
fp_format_pkg.sv
sig_multiplier.sv
exp_sign_path.sv
result_normalizer.sv
fp_multiplier.sv
tb_fp_multiplier.sv

//--- Makefile
TOP = tb_fp_multiplier

.PHONY: sim clean

sim:
	verilator --binary --assert -j 0 --top-module $(TOP) -f verilog.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q '>>> PASS'

clean:
	rm -rf obj_dir
